// ==== src/cache_geom_pkg.sv ====
package cache_geom_pkg;

    localparam int unsigned word_w         = 32;
    localparam int unsigned words_per_line = 4;
    localparam int unsigned num_lines      = 8;
    localparam int unsigned index_w        = 3;
    localparam int unsigned offset_w       = 2;
    localparam int unsigned tag_w          = 25;
    localparam int unsigned proc_addr_w    = 30;  // word address
    localparam int unsigned block_addr_w   = 28;
    localparam int unsigned block_w        = 128;

    typedef logic [word_w-1:0] word_t;

    // word 0 sits in the low bits
    typedef logic [words_per_line-1:0][word_w-1:0] block_t;

    typedef logic [tag_w-1:0]    tag_t;
    typedef logic [index_w-1:0]  index_t;
    typedef logic [offset_w-1:0] offset_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } proc_addr_t;

    typedef struct packed {
        logic   dirty;
        logic   valid;
        tag_t   tag;
        block_t data;
    } line_state_t;

endpackage

// ==== src/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

    typedef enum logic [1:0] {
        idle       = 2'd0,
        write_back = 2'd1,  // victim block out to memory
        refill     = 2'd2   // new block in from memory
    } ctrl_state_t;

    typedef struct packed {
        logic                                    read;
        logic                                    write;
        logic [cache_geom_pkg::block_addr_w-1:0] addr;
        cache_geom_pkg::block_t                  wdata;
    } mem_req_t;

    // one bus to all lines, only the indexed line acts
    typedef struct packed {
        logic                    refill;
        logic                    word_write;
        logic                    clean;
        cache_geom_pkg::index_t  index;
        cache_geom_pkg::offset_t offset;
        cache_geom_pkg::tag_t    tag;
        cache_geom_pkg::word_t   wdata;
        cache_geom_pkg::block_t  fill_data;
    } line_update_t;

endpackage

// ==== src/cache_line.sv ====
`timescale 1ns/10ps

module cache_line #(
    parameter int unsigned line_id = 0
) (
    input  logic                         clk,
    input  logic                         proc_reset,
    input  cache_ctrl_pkg::line_update_t upd,
    output cache_geom_pkg::line_state_t  state
);

    logic                   sel;
    logic                   valid_q;
    logic                   dirty_q;
    cache_geom_pkg::tag_t   tag_q;
    cache_geom_pkg::block_t data_q;

    assign sel = (upd.index == cache_geom_pkg::index_t'(line_id));

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end
        else if (sel)
        begin
            if (upd.refill)
            begin
                valid_q <= 1'b1;
                dirty_q <= 1'b0;  // fresh copy of memory
            end
            else if (upd.word_write)
            begin
                dirty_q <= 1'b1;
            end
            else if (upd.clean)
            begin
                dirty_q <= 1'b0;  // victim accepted by memory
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (sel && upd.refill)
        begin
            tag_q  <= upd.tag;
            data_q <= upd.fill_data;
        end
        else if (sel && upd.word_write)
        begin
            data_q[upd.offset] <= upd.wdata;  // one word only
        end
    end

    assign state = '{dirty: dirty_q, valid: valid_q, tag: tag_q, data: data_q};

endmodule

// ==== src/line_select.sv ====
`timescale 1ns/10ps

module line_select (
    input  cache_geom_pkg::line_state_t lines [cache_geom_pkg::num_lines],
    input  cache_geom_pkg::proc_addr_t  addr,
    output logic                        hit,
    output cache_geom_pkg::line_state_t victim,
    output cache_geom_pkg::word_t       rdata
);

    cache_geom_pkg::line_state_t cur;
    logic                        tag_match;

    // mux of the indexed line
    always_comb
    begin
        cur = lines[0];
        for (int i = 0; i < cache_geom_pkg::num_lines; i++)
        begin
            if (addr.index == cache_geom_pkg::index_t'(i))
            begin
                cur = lines[i];
            end
        end
    end

    assign tag_match = (cur.tag == addr.tag);
    assign hit       = cur.valid && tag_match;  // invalid line never hits

    // whole line goes out, the controller decides if it is written back
    assign victim = cur;

    assign rdata = cur.data[addr.offset];

endmodule

// ==== src/cache_ctrl.sv ====
`timescale 1ns/10ps

module cache_ctrl (
    input  logic                                clk,
    input  logic                                proc_reset,
    input  logic                                proc_read,
    input  logic                                proc_write,
    input  cache_geom_pkg::proc_addr_t          proc_addr,
    input  cache_geom_pkg::word_t               proc_wdata,
    input  logic                                hit,
    input  cache_geom_pkg::line_state_t         victim,
    input  logic                                mem_ready,
    input  cache_geom_pkg::block_t              mem_rdata,
    output cache_ctrl_pkg::mem_req_t            mem_req,
    output cache_ctrl_pkg::line_update_t        upd,
    output logic                                proc_stall
);

    cache_ctrl_pkg::ctrl_state_t             state;
    cache_ctrl_pkg::ctrl_state_t             state_next;
    logic                                    req;
    logic                                    miss;
    logic                                    dirty_victim;
    logic                                    load_wb;
    logic                                    load_fill;
    logic                                    req_read;
    logic                                    req_write;
    logic [cache_geom_pkg::block_addr_w-1:0] req_addr;
    cache_geom_pkg::block_t                  req_wdata;

    assign req          = proc_read || proc_write;
    assign miss         = req && !hit;
    assign dirty_victim = victim.valid && victim.dirty;

    assign proc_stall = miss || (state != cache_ctrl_pkg::idle);

    always_comb
    begin
        state_next = state;
        load_wb    = 1'b0;
        load_fill  = 1'b0;
        case (state)
            cache_ctrl_pkg::idle:
            begin
                if (miss && dirty_victim)
                begin
                    state_next = cache_ctrl_pkg::write_back;
                    load_wb    = 1'b1;
                end
                else if (miss)
                begin
                    state_next = cache_ctrl_pkg::refill;
                    load_fill  = 1'b1;
                end
            end
            cache_ctrl_pkg::write_back:
            begin
                if (mem_ready)
                begin
                    state_next = cache_ctrl_pkg::refill;  // straight into the read
                    load_fill  = 1'b1;
                end
            end
            cache_ctrl_pkg::refill:
            begin
                if (mem_ready)
                begin
                    state_next = cache_ctrl_pkg::idle;
                end
            end
            default:
            begin
                state_next = cache_ctrl_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            state     <= cache_ctrl_pkg::idle;
            req_read  <= 1'b0;
            req_write <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            req_write <= (state_next == cache_ctrl_pkg::write_back);  // held until ready
            req_read  <= (state_next == cache_ctrl_pkg::refill);
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_wb)
        begin
            req_addr  <= {victim.tag, proc_addr.index};  // victim block address
            req_wdata <= victim.data;
        end
        else if (load_fill)
        begin
            req_addr <= {proc_addr.tag, proc_addr.index};
        end
    end

    assign mem_req = '{read: req_read, write: req_write, addr: req_addr, wdata: req_wdata};

    always_comb
    begin
        upd.refill     = (state == cache_ctrl_pkg::refill) && mem_ready;
        upd.word_write = (state == cache_ctrl_pkg::idle) && proc_write && hit;
        upd.clean      = (state == cache_ctrl_pkg::write_back) && mem_ready;
        upd.index      = proc_addr.index;  // address held through the stall
        upd.offset     = proc_addr.offset;
        upd.tag        = proc_addr.tag;
        upd.wdata      = proc_wdata;
        upd.fill_data  = mem_rdata;
    end

endmodule

// ==== src/cache_top.sv ====
`timescale 1ns/10ps

module cache_top (
    input  logic                                    clk,
    input  logic                                    proc_reset,
    input  logic                                    proc_read,
    input  logic                                    proc_write,
    input  logic [cache_geom_pkg::proc_addr_w-1:0]  proc_addr,
    input  cache_geom_pkg::word_t                   proc_wdata,
    output cache_geom_pkg::word_t                   proc_rdata,
    output logic                                    proc_stall,
    output logic                                    mem_read,
    output logic                                    mem_write,
    output logic [cache_geom_pkg::block_addr_w-1:0] mem_addr,
    output cache_geom_pkg::block_t                  mem_wdata,
    input  cache_geom_pkg::block_t                  mem_rdata,
    input  logic                                    mem_ready
);

    cache_geom_pkg::proc_addr_t   addr;
    cache_geom_pkg::line_state_t  lines [cache_geom_pkg::num_lines];
    cache_geom_pkg::line_state_t  victim;
    cache_ctrl_pkg::line_update_t upd;
    cache_ctrl_pkg::mem_req_t     mem_req;
    logic                         hit;

    assign addr = proc_addr;  // tag / index / offset view

    assign mem_read  = mem_req.read;
    assign mem_write = mem_req.write;
    assign mem_addr  = mem_req.addr;
    assign mem_wdata = mem_req.wdata;

    cache_ctrl u_ctrl (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (addr),
        .proc_wdata (proc_wdata),
        .hit        (hit),
        .victim     (victim),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .mem_req    (mem_req),
        .upd        (upd),
        .proc_stall (proc_stall)
    );

    for (genvar i = 0; i < cache_geom_pkg::num_lines; i++)
    begin : g_line
        cache_line #(.line_id(i)) u_line (
            .clk        (clk),
            .proc_reset (proc_reset),
            .upd        (upd),
            .state      (lines[i])
        );
    end

    line_select u_select (
        .lines  (lines),
        .addr   (addr),
        .hit    (hit),
        .victim (victim),
        .rdata  (proc_rdata)
    );

endmodule

// ==== tests/cache_properties.sv ====
`timescale 1ns/10ps

module cache_properties (
    input logic                                    clk,
    input logic                                    proc_reset,
    input logic                                    proc_read,
    input logic                                    proc_write,
    input logic                                    proc_stall,
    input logic                                    hit,
    input logic                                    mem_read,
    input logic                                    mem_write,
    input logic                                    mem_ready,
    input logic [cache_geom_pkg::block_addr_w-1:0] mem_addr,
    input cache_geom_pkg::block_t                  mem_wdata
);

    int prop_errors = 0;

    one_request: assert property (@(posedge clk) disable iff (proc_reset)
        !(mem_read && mem_write))
    else
    begin
        $error("mem_read and mem_write high together");
        prop_errors++;
    end

    addr_held: assert property (@(posedge clk) disable iff (proc_reset)
        (mem_read || mem_write) && !mem_ready |=> $stable(mem_addr))
    else
    begin
        $error("mem_addr changed while waiting for mem_ready");
        prop_errors++;
    end

    // only writes carry block data
    wdata_held: assert property (@(posedge clk) disable iff (proc_reset)
        mem_write && !mem_ready |=> $stable(mem_wdata))
    else
    begin
        $error("mem_wdata changed while waiting for mem_ready");
        prop_errors++;
    end

    hit_no_stall: assert property (@(posedge clk) disable iff (proc_reset)
        (proc_read || proc_write) && hit |-> !proc_stall)
    else
    begin
        $error("proc_stall high on a hit");
        prop_errors++;
    end

endmodule

bind cache_top cache_properties props_i (
    .clk        (clk),
    .proc_reset (proc_reset),
    .proc_read  (proc_read),
    .proc_write (proc_write),
    .proc_stall (proc_stall),
    .hit        (hit),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_ready  (mem_ready),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata)
);

// ==== tests/cache_tb.sv ====
`timescale 1ns/10ps

module cache_tb;

    localparam int timeout_cycles = 200;

    typedef struct packed {
        logic                                    write;
        logic [cache_geom_pkg::block_addr_w-1:0] addr;
        cache_geom_pkg::block_t                  data;
    } mem_event_t;

    logic                                    clk;
    logic                                    proc_reset;
    logic                                    proc_read;
    logic                                    proc_write;
    logic [cache_geom_pkg::proc_addr_w-1:0]  proc_addr;
    cache_geom_pkg::word_t                   proc_wdata;
    cache_geom_pkg::word_t                   proc_rdata;
    logic                                    proc_stall;
    logic                                    mem_read;
    logic                                    mem_write;
    logic [cache_geom_pkg::block_addr_w-1:0] mem_addr;
    cache_geom_pkg::block_t                  mem_wdata;
    cache_geom_pkg::block_t                  mem_rdata;
    logic                                    mem_ready;

    cache_geom_pkg::block_t mem [logic [cache_geom_pkg::block_addr_w-1:0]];
    cache_geom_pkg::word_t  shadow [logic [cache_geom_pkg::proc_addr_w-1:0]];
    mem_event_t             req_log [$];  // accepted memory requests in order
    int                     seed;
    int                     wait_cnt;
    int                     mem_reads;
    int                     mem_writes;
    int                     checks;
    int                     errors;
    int                     test_errors;
    int                     tests;

    cache_top dut_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    always #2 clk = ~clk;

    function automatic cache_geom_pkg::word_t init_word(input logic [29:0] waddr);
        return 32'(waddr) ^ 32'h5a5a0000;
    endfunction

    function automatic cache_geom_pkg::block_t mem_block(input logic [27:0] baddr);
        cache_geom_pkg::block_t blk;
        if (mem.exists(baddr))
        begin
            return mem[baddr];
        end
        for (int w = 0; w < cache_geom_pkg::words_per_line; w++)
        begin
            blk[w] = init_word({baddr, 2'(w)});
        end
        return blk;
    endfunction

    function automatic cache_geom_pkg::word_t expected_word(input logic [29:0] waddr);
        return shadow.exists(waddr) ? shadow[waddr] : init_word(waddr);
    endfunction

    // memory model, ready after 0 to 3 cycles
    always @(posedge clk)
    begin
        #1;
        if (mem_ready || proc_reset)
        begin
            mem_ready = 1'b0;  // accepted at this edge
            wait_cnt  = -1;
        end
        if (!proc_reset && (mem_read || mem_write))
        begin
            if (wait_cnt < 0)
            begin
                wait_cnt = $unsigned($random(seed)) % 4;
            end
            if (wait_cnt == 0)
            begin
                if (mem_write)
                begin
                    mem[mem_addr] = mem_wdata;
                    mem_writes++;
                end
                else
                begin
                    mem_rdata = mem_block(mem_addr);
                    mem_reads++;
                end
                req_log.push_back('{write: mem_write, addr: mem_addr, data: mem_wdata});
                mem_ready = 1'b1;
            end
            else
            begin
                wait_cnt--;
            end
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("timeout after %0d cycles: %s", timeout_cycles, what);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_true(input string name, input logic cond, input string what);
        checks++;
        assert (cond === 1'b1)
        else
        begin
            $display("Error in %s: %s", name, what);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errors == 0)
        begin
            $display("test %s passed", name);
        end
        else
        begin
            $display("test %s failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic start_access(input logic wr, input logic [29:0] a, input logic [31:0] wd);
        proc_read  = !wr;
        proc_write = wr;
        proc_addr  = a;
        proc_wdata = wd;
    endtask

    // called 1 ns after an edge, samples 1 ns before the next
    task automatic finish_access(input string name, output cache_geom_pkg::word_t rd);
        int n;
        n = 0;
        #2;
        while (proc_stall && n < timeout_cycles)
        begin
            @(posedge clk);
            #3;
            n++;
        end
        if (proc_stall)
        begin
            abort_on_timeout({name, ": proc_stall never fell"});
        end
        else
        begin
            rd = proc_rdata;
            if (proc_write)
            begin
                shadow[proc_addr] = proc_wdata;  // taken at the coming edge
            end
            @(posedge clk);
            #1;
            proc_read  = 1'b0;
            proc_write = 1'b0;
        end
    endtask

    task automatic wait_mem_req(input string name);
        int n;
        n = 0;
        do
        begin
            @(posedge clk);
            #1;
            n++;
        end
        while (!(mem_read || mem_write) && n < timeout_cycles);
        if (!(mem_read || mem_write))
        begin
            abort_on_timeout({name, ": no memory request appeared"});
        end
    endtask

    task automatic do_read(input string name, input logic [29:0] a);
        cache_geom_pkg::word_t rd;
        start_access(1'b0, a, '0);
        finish_access(name, rd);
        check_word(name, expected_word(a), rd);
    endtask

    task automatic do_write(input string name, input logic [29:0] a, input logic [31:0] d);
        cache_geom_pkg::word_t rd;
        start_access(1'b1, a, d);
        finish_access(name, rd);
    endtask

    initial
    begin
        cache_geom_pkg::word_t first_rd;
        int                    base;
        logic [29:0]           a;
        seed        = 32'h14e5;
        wait_cnt    = -1;
        mem_reads   = 0;
        mem_writes  = 0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        tests       = 0;
        clk         = 1'b0;
        proc_reset  = 1'b1;
        proc_read   = 1'b0;
        proc_write  = 1'b0;
        proc_addr   = '0;
        proc_wdata  = '0;
        mem_rdata   = '0;
        mem_ready   = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        proc_reset = 1'b0;

        check_true("reset_miss", !mem_read && !mem_write, "memory request active after reset");
        check_true("reset_miss", !proc_stall, "proc_stall high after reset");
        start_access(1'b0, 30'h40, '0);
        #2;
        check_true("reset_miss", proc_stall, "first read did not stall");
        wait_mem_req("reset_miss");
        check_true("reset_miss", mem_read && !mem_write, "miss raised no memory read");
        finish_access("reset_miss", first_rd);
        end_test("reset_miss");

        check_word("read_miss_hits", init_word(30'h40), first_rd);
        base = mem_reads;
        do_read("read_miss_hits", 30'h41);
        do_read("read_miss_hits", 30'h42);
        do_read("read_miss_hits", 30'h43);
        check_word("read_miss_hits", base, mem_reads);  // no refill for the same block
        end_test("read_miss_hits");

        base = mem_reads + mem_writes;
        do_write("write_hit", 30'h41, 32'hcafe0041);
        do_read("write_hit", 30'h41);
        check_word("write_hit", base, mem_reads + mem_writes);
        end_test("write_hit");

        do_write("dirty_evict", 30'h42, 32'hbeef0042);
        req_log.delete();
        do_read("dirty_evict", 30'h60);  // block 0x18, same index as 0x10
        check_word("dirty_evict", 2, req_log.size());
        if (req_log.size() >= 2)
        begin
            check_true("dirty_evict", req_log[0].write, "write-back was not first");
            check_word("dirty_evict", 28'h10, req_log[0].addr);
            check_word("dirty_evict", 32'hbeef0042, req_log[0].data[2]);
            check_true("dirty_evict", !req_log[1].write, "refill read did not follow");
            check_word("dirty_evict", 28'h18, req_log[1].addr);
        end
        do_read("dirty_evict", 30'h42);
        do_read("dirty_evict", 30'h41);
        end_test("dirty_evict");

        for (int i = 0; i < 300; i++)
        begin
            a = 30'($unsigned($random(seed)) % 64);
            if ($random(seed) & 1)
            begin
                do_write("random_traffic", a, $random(seed));
            end
            else
            begin
                do_read("random_traffic", a);
            end
        end
        end_test("random_traffic");

        errors = errors + dut_i.props_i.prop_errors;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
src/cache_geom_pkg.sv
src/cache_ctrl_pkg.sv
src/cache_line.sv
src/line_select.sv
src/cache_ctrl.sv
src/cache_top.sv
tests/cache_properties.sv
tests/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache

sources:
  - src/cache_geom_pkg.sv
  - src/cache_ctrl_pkg.sv
  - src/cache_line.sv
  - src/line_select.sv
  - src/cache_ctrl.sv
  - src/cache_top.sv
  - target: test
    files:
      - tests/cache_properties.sv
      - tests/cache_tb.sv
